//--- Makefile
# Verilator build and run for the accelerator front end

VERILATOR ?= verilator
TOP       ?= accel_wrap_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing --assert

SOURCES := $(wildcard hw/*.sv verification/*.sv)

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "tests failed" $(LOG); then exit 1; fi
	@grep -q "all tests passed" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- hw/accel_csr.sv
`timescale 1ns/1ns
`default_nettype none

module accel_csr (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                io_en,
  input  logic                                io_wen,
  input  logic [accel_pkg::IO_STRB_WIDTH-1:0] io_strb,
  input  logic [accel_pkg::IO_ADDR_WIDTH-1:0] io_addr,
  input  logic [accel_pkg::IO_DATA_WIDTH-1:0] io_wr_data,
  output logic [accel_pkg::IO_DATA_WIDTH-1:0] io_rd_data,
  output logic                                io_rd_valid,
  desc_if.csr                                 desc,
  flow_rd_if.csr                              flow,
  input  logic                                dma_ready,
  input  logic                                dma_last_beat,
  output logic                                dma_stop
);
  import accel_pkg::*;

  logic                       wr_access;
  logic                       rd_access;
  logic [IO_ADDR_WIDTH-1:0]   reg_off;
  logic                       in_burst;
  logic [BURST_WORD_BITS-1:0] burst_word;
  logic [IO_DATA_WIDTH-1:0]   burst_rd_data;
  logic                       burst_hit;
  logic [IO_DATA_WIDTH-1:0]   wr_mask;
  logic [IO_DATA_WIDTH-1:0]   status_word;
  logic [IO_DATA_WIDTH-1:0]   rd_mux;

  logic [LEN_WIDTH-1:0]       len_reg;
  logic [ACC_ADDR_WIDTH-1:0]  addr_reg;
  logic                       mode_32b;
  logic                       stall;
  logic                       done;
  logic                       done_err;

  assign wr_access = io_en && io_wen;
  assign rd_access = io_en && !io_wen;
  assign reg_off   = {io_addr[IO_ADDR_WIDTH-1:2], 2'b00};

  // 0x40..0x5c window onto the fetched 256-bit result
  assign in_burst = reg_off[IO_ADDR_WIDTH-1:BURST_WORD_BITS+2] ==
                    REG_FLOW_BURST_BASE[IO_ADDR_WIDTH-1:BURST_WORD_BITS+2];
  assign burst_word    = io_addr[BURST_WORD_BITS+1:2];
  assign burst_rd_data = flow.data[burst_word*IO_DATA_WIDTH +: IO_DATA_WIDTH];

  // ready may still show the old result in the request cycle
  assign burst_hit = flow.ready && !flow.req;

  assign status_word = {15'd0, done_err, 7'd0, done, 7'd0, !dma_ready};

  assign desc.push_addr = addr_reg;
  assign desc.push_len  = len_reg;

  always_comb begin
    for (int b = 0; b < IO_STRB_WIDTH; b++) begin
      wr_mask[8*b +: 8] = {8{io_strb[b]}};
    end
  end

  always_comb begin
    rd_mux = '0;
    case (reg_off)
      REG_DMA_LEN:   rd_mux = IO_DATA_WIDTH'(len_reg);
      REG_DMA_ADDR:  rd_mux = IO_DATA_WIDTH'(addr_reg);
      REG_FLOW_MODE: rd_mux = IO_DATA_WIDTH'(mode_32b);
      REG_STATUS:    rd_mux = status_word;
      default: begin
        if (in_burst) begin
          rd_mux = burst_rd_data;
        end
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      desc.push   <= 1'b0;
      dma_stop    <= 1'b0;
      flow.req    <= 1'b0;
      mode_32b    <= 1'b0;
      io_rd_valid <= 1'b0;
      stall       <= 1'b0;
      done        <= 1'b0;
      done_err    <= 1'b0;
    end else begin
      desc.push   <= 1'b0;
      dma_stop    <= 1'b0;
      flow.req    <= 1'b0;
      io_rd_valid <= 1'b0;

      // sticky status
      done     <= done | dma_last_beat | dma_stop;
      done_err <= done_err | (done & !dma_ready);

      if (wr_access) begin
        case (reg_off)
          REG_CTRL: begin
            if (io_strb[0]) begin
              desc.push <= io_wr_data[0];
              dma_stop  <= io_wr_data[2];
            end
          end
          REG_FLOW_REQ:  flow.req <= 1'b1;
          REG_FLOW_MODE: begin
            if (io_strb[0]) begin
              mode_32b <= io_wr_data[0];
            end
          end
          default: ;
        endcase
      end

      if (rd_access) begin
        if (in_burst) begin
          io_rd_valid <= burst_hit;
          stall       <= !burst_hit;
        end else begin
          io_rd_valid <= 1'b1;
        end
      end

      // core holds io_addr while stalled, keep retrying
      if (stall) begin
        io_rd_valid <= flow.ready;
        stall       <= !flow.ready;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_access) begin
      case (reg_off)
        REG_DMA_LEN: begin
          len_reg <= (len_reg & ~wr_mask[LEN_WIDTH-1:0]) |
                     (io_wr_data[LEN_WIDTH-1:0] & wr_mask[LEN_WIDTH-1:0]);
        end
        REG_DMA_ADDR: begin
          addr_reg <= (addr_reg & ~wr_mask[ACC_ADDR_WIDTH-1:0]) |
                      (io_wr_data[ACC_ADDR_WIDTH-1:0] & wr_mask[ACC_ADDR_WIDTH-1:0]);
        end
        REG_FLOW_REQ: begin
          if (mode_32b) begin
            flow.addr  <= io_wr_data[ACC_ADDR_WIDTH-1:0];
            flow.block <= io_wr_data[ACC_ADDR_WIDTH +: HASH_SEL_BITS];
            flow.bank  <= 1'b0;
          end else begin
            // 16-byte mode, bit 0 picks the bank
            flow.addr  <= io_wr_data[ACC_ADDR_WIDTH:1];
            flow.block <= io_wr_data[ACC_ADDR_WIDTH+1 +: HASH_SEL_BITS];
            flow.bank  <= io_wr_data[0];
          end
        end
        default: ;
      endcase
    end

    if (rd_access) begin
      io_rd_data <= rd_mux;
    end
    if (stall) begin
      io_rd_data <= burst_rd_data;
    end
  end

endmodule

`default_nettype wire

//--- hw/accel_ifs.sv
`timescale 1ns/1ns
`default_nettype none

// descriptor path, register block -> queue -> dma engine
interface desc_if;
  import accel_pkg::*;

  logic                      push;
  logic [ACC_ADDR_WIDTH-1:0] push_addr;
  logic [LEN_WIDTH-1:0]      push_len;
  logic [ACC_ADDR_WIDTH-1:0] line_addr;
  logic [LEN_WIDTH-1:0]      len;
  logic                      valid;
  logic                      ready;

  modport csr  (output push, push_addr, push_len);
  modport fifo (input push, push_addr, push_len, ready, output valid, line_addr, len);
  modport dma  (input valid, line_addr, len, output ready);
endinterface

// hash table burst read request and result
interface flow_rd_if;
  import accel_pkg::*;

  logic                       req;
  logic [ACC_ADDR_WIDTH-1:0]  addr;
  logic [HASH_SEL_BITS-1:0]   block;
  logic                       bank;
  logic [FLOW_DATA_WIDTH-1:0] data;
  logic                       ready;

  modport csr    (output req, addr, block, bank, input data, ready);
  modport reader (input req, addr, block, bank, output data, ready);
endinterface

`default_nettype wire

//--- hw/accel_pkg.sv
`default_nettype none

package accel_pkg;

  // register bus
  localparam int IO_DATA_WIDTH = 32;
  localparam int IO_STRB_WIDTH = 4;
  localparam int IO_ADDR_WIDTH = 7;

  // memory lines and stream
  localparam int DATA_WIDTH      = 128;
  localparam int EMPTY_WIDTH     = 4;
  localparam int ACC_ADDR_WIDTH  = 12;
  localparam int FLOW_DATA_WIDTH = 2 * DATA_WIDTH;

  // hash table organisation
  localparam int HASH_TABLE_BLOCKS = 4;
  localparam int HASH_SEL_BITS     = $clog2(HASH_TABLE_BLOCKS);
  localparam int BURST_WORD_BITS   = $clog2(FLOW_DATA_WIDTH / IO_DATA_WIDTH);

  // descriptors
  localparam int LEN_WIDTH       = 14;
  localparam int LINE_CNT_WIDTH  = LEN_WIDTH - EMPTY_WIDTH + 1;
  localparam int DESC_DEPTH_BITS = 4;
  localparam int DESC_DEPTH      = 2 ** DESC_DEPTH_BITS;

  // memory read latency, enable to data
  localparam int MEM_RD_LATENCY = 2;
  localparam int WAIT_CNT_WIDTH = $clog2(MEM_RD_LATENCY + 1);

  // register offsets
  localparam logic [IO_ADDR_WIDTH-1:0] REG_CTRL            = 7'h00;
  localparam logic [IO_ADDR_WIDTH-1:0] REG_DMA_LEN         = 7'h04;
  localparam logic [IO_ADDR_WIDTH-1:0] REG_DMA_ADDR        = 7'h08;
  localparam logic [IO_ADDR_WIDTH-1:0] REG_FLOW_BURST_BASE = 7'h40;
  localparam logic [IO_ADDR_WIDTH-1:0] REG_FLOW_REQ        = 7'h60;
  localparam logic [IO_ADDR_WIDTH-1:0] REG_FLOW_MODE       = 7'h64;
  localparam logic [IO_ADDR_WIDTH-1:0] REG_STATUS          = 7'h78;

  typedef enum logic [1:0] {
    DMA_IDLE,
    DMA_REQ,
    DMA_WAIT,
    DMA_SEND
  } dma_state_t;

endpackage

`default_nettype wire

//--- hw/accel_wrap.sv
`timescale 1ns/1ns
`default_nettype none

module accel_wrap (
  input  logic                                 clk,
  input  logic                                 rst,

  input  logic                                 io_en,
  input  logic                                 io_wen,
  input  logic [accel_pkg::IO_STRB_WIDTH-1:0]  io_strb,
  input  logic [accel_pkg::IO_ADDR_WIDTH-1:0]  io_addr,
  input  logic [accel_pkg::IO_DATA_WIDTH-1:0]  io_wr_data,
  output logic [accel_pkg::IO_DATA_WIDTH-1:0]  io_rd_data,
  output logic                                 io_rd_valid,

  output logic                                 ft_en,
  output logic [accel_pkg::ACC_ADDR_WIDTH-1:0] ft_addr,
  input  logic [accel_pkg::HASH_TABLE_BLOCKS-1:0][accel_pkg::DATA_WIDTH-1:0] ft_rd_data_b1,
  input  logic [accel_pkg::HASH_TABLE_BLOCKS-1:0][accel_pkg::DATA_WIDTH-1:0] ft_rd_data_b2,

  output logic                                 pkt_en,
  output logic [accel_pkg::ACC_ADDR_WIDTH-1:0] pkt_addr,
  input  logic [accel_pkg::DATA_WIDTH-1:0]     pkt_rd_data,

  output logic [accel_pkg::DATA_WIDTH-1:0]     stream_data,
  output logic [accel_pkg::EMPTY_WIDTH-1:0]    stream_empty,
  output logic                                 stream_last,
  output logic                                 stream_valid,
  input  logic                                 stream_ready
);

  desc_if    desc_bus ();
  flow_rd_if flow_bus ();

  logic dma_stop;
  logic dma_last_beat;

  // last beat actually transferred
  assign dma_last_beat = stream_valid && stream_ready && stream_last;

  accel_csr csr_inst (
    .clk          (clk),
    .rst          (rst),
    .io_en        (io_en),
    .io_wen       (io_wen),
    .io_strb      (io_strb),
    .io_addr      (io_addr),
    .io_wr_data   (io_wr_data),
    .io_rd_data   (io_rd_data),
    .io_rd_valid  (io_rd_valid),
    .desc         (desc_bus.csr),
    .flow         (flow_bus.csr),
    .dma_ready    (desc_bus.ready),
    .dma_last_beat(dma_last_beat),
    .dma_stop     (dma_stop)
  );

  desc_fifo desc_fifo_inst (
    .clk (clk),
    .rst (rst),
    .desc(desc_bus.fifo)
  );

  flow_table_reader flow_reader_inst (
    .clk          (clk),
    .rst          (rst),
    .flow         (flow_bus.reader),
    .ft_en        (ft_en),
    .ft_addr      (ft_addr),
    .ft_rd_data_b1(ft_rd_data_b1),
    .ft_rd_data_b2(ft_rd_data_b2)
  );

  line_rd_dma dma_inst (
    .clk         (clk),
    .rst         (rst),
    .desc        (desc_bus.dma),
    .stop        (dma_stop),
    .pkt_en      (pkt_en),
    .pkt_addr    (pkt_addr),
    .pkt_rd_data (pkt_rd_data),
    .stream_data (stream_data),
    .stream_empty(stream_empty),
    .stream_last (stream_last),
    .stream_valid(stream_valid),
    .stream_ready(stream_ready)
  );

endmodule

`default_nettype wire

//--- hw/desc_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module desc_fifo (
  input  logic clk,
  input  logic rst,
  desc_if.fifo desc
);
  import accel_pkg::*;

  logic [ACC_ADDR_WIDTH-1:0]  addr_mem [DESC_DEPTH];
  logic [LEN_WIDTH-1:0]       len_mem  [DESC_DEPTH];
  logic [DESC_DEPTH_BITS-1:0] wr_ptr;
  logic [DESC_DEPTH_BITS-1:0] rd_ptr;
  logic [DESC_DEPTH_BITS:0]   count;
  logic                       wr_ok;
  logic                       pop;

  // a push into a full queue is dropped
  assign wr_ok = desc.push && (count != DESC_DEPTH);
  assign pop   = desc.valid && desc.ready;

  assign desc.valid     = count != 0;
  assign desc.line_addr = addr_mem[rd_ptr];
  assign desc.len       = len_mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_ok) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({wr_ok, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (wr_ok) begin
      addr_mem[wr_ptr] <= desc.push_addr;
      len_mem[wr_ptr]  <= desc.push_len;
    end
  end

endmodule

`default_nettype wire

//--- hw/flow_table_reader.sv
`timescale 1ns/1ns
`default_nettype none

module flow_table_reader (
  input  logic                                 clk,
  input  logic                                 rst,
  flow_rd_if.reader                            flow,
  output logic                                 ft_en,
  output logic [accel_pkg::ACC_ADDR_WIDTH-1:0] ft_addr,
  input  logic [accel_pkg::HASH_TABLE_BLOCKS-1:0][accel_pkg::DATA_WIDTH-1:0] ft_rd_data_b1,
  input  logic [accel_pkg::HASH_TABLE_BLOCKS-1:0][accel_pkg::DATA_WIDTH-1:0] ft_rd_data_b2
);
  import accel_pkg::*;

  // stage 0 drives the memories, last stage lines up with read data
  logic [MEM_RD_LATENCY:0]                    vld_pipe;
  logic [MEM_RD_LATENCY:0][HASH_SEL_BITS-1:0] blk_pipe;
  logic [MEM_RD_LATENCY:0]                    bank_pipe;
  logic [DATA_WIDTH-1:0]                      line_b1;
  logic [DATA_WIDTH-1:0]                      line_b2;

  assign ft_en   = vld_pipe[0];
  assign line_b1 = ft_rd_data_b1[blk_pipe[MEM_RD_LATENCY]];
  assign line_b2 = ft_rd_data_b2[blk_pipe[MEM_RD_LATENCY]];

  always_ff @(posedge clk) begin
    if (rst) begin
      vld_pipe   <= '0;
      flow.ready <= 1'b0;
    end else begin
      vld_pipe <= {vld_pipe[MEM_RD_LATENCY-1:0], flow.req};
      // held until the next request
      flow.ready <= vld_pipe[MEM_RD_LATENCY] || (flow.ready && !flow.req);
    end
  end

  always_ff @(posedge clk) begin
    ft_addr   <= flow.addr;
    blk_pipe  <= {blk_pipe[MEM_RD_LATENCY-1:0], flow.block};
    bank_pipe <= {bank_pipe[MEM_RD_LATENCY-1:0], flow.bank};

    // bank 1 swaps the halves
    if (vld_pipe[MEM_RD_LATENCY]) begin
      flow.data <= bank_pipe[MEM_RD_LATENCY] ? {line_b1, line_b2} : {line_b2, line_b1};
    end
  end

endmodule

`default_nettype wire

//--- hw/line_rd_dma.sv
`timescale 1ns/1ns
`default_nettype none

module line_rd_dma (
  input  logic                                 clk,
  input  logic                                 rst,
  desc_if.dma                                  desc,
  input  logic                                 stop,
  output logic                                 pkt_en,
  output logic [accel_pkg::ACC_ADDR_WIDTH-1:0] pkt_addr,
  input  logic [accel_pkg::DATA_WIDTH-1:0]     pkt_rd_data,
  output logic [accel_pkg::DATA_WIDTH-1:0]     stream_data,
  output logic [accel_pkg::EMPTY_WIDTH-1:0]    stream_empty,
  output logic                                 stream_last,
  output logic                                 stream_valid,
  input  logic                                 stream_ready
);
  import accel_pkg::*;

  dma_state_t                state;
  logic [ACC_ADDR_WIDTH-1:0] line_addr;
  logic [LINE_CNT_WIDTH-1:0] lines_left;
  logic [LINE_CNT_WIDTH-1:0] desc_lines;
  logic [EMPTY_WIDTH-1:0]    last_empty;
  logic [WAIT_CNT_WIDTH-1:0] wait_cnt;
  logic                      wait_done;
  logic                      take;

  // length in 16-byte lines, rounded up, never zero
  always_comb begin
    desc_lines = desc.len[LEN_WIDTH-1:EMPTY_WIDTH] + (desc.len[EMPTY_WIDTH-1:0] != 0);
    if (desc_lines == 0) begin
      desc_lines = 1;
    end
  end

  assign desc.ready = (state == DMA_IDLE) && !stop;
  assign take       = desc.valid && desc.ready;
  assign wait_done  = wait_cnt == WAIT_CNT_WIDTH'(MEM_RD_LATENCY - 1);

  assign pkt_en       = state == DMA_REQ;
  assign pkt_addr     = line_addr;
  assign stream_valid = state == DMA_SEND;
  assign stream_last  = lines_left == 1;
  assign stream_empty = stream_last ? last_empty : '0;

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= DMA_IDLE;
      wait_cnt <= '0;
    end else if (stop) begin
      // drop whatever is in flight
      state <= DMA_IDLE;
    end else begin
      case (state)
        DMA_IDLE: begin
          if (take) begin
            state <= DMA_REQ;
          end
        end
        DMA_REQ: begin
          wait_cnt <= '0;
          state    <= DMA_WAIT;
        end
        DMA_WAIT: begin
          if (wait_done) begin
            state <= DMA_SEND;
          end else begin
            wait_cnt <= wait_cnt + 1'b1;
          end
        end
        DMA_SEND: begin
          if (stream_ready) begin
            state <= stream_last ? DMA_IDLE : DMA_REQ;
          end
        end
        default: state <= DMA_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      line_addr  <= desc.line_addr;
      lines_left <= desc_lines;
      last_empty <= {EMPTY_WIDTH{1'b0}} - desc.len[EMPTY_WIDTH-1:0];
    end else if (stream_valid && stream_ready) begin
      line_addr  <= line_addr + 1'b1;
      lines_left <= lines_left - 1'b1;
    end

    // line held here until the beat is taken
    if (state == DMA_WAIT && wait_done) begin
      stream_data <= pkt_rd_data;
    end
  end

endmodule

`default_nettype wire

//--- project.f
hw/accel_pkg.sv
hw/accel_ifs.sv
hw/accel_csr.sv
hw/desc_fifo.sv
hw/flow_table_reader.sv
hw/line_rd_dma.sv
hw/accel_wrap.sv
verification/accel_wrap_assert.sv
verification/accel_wrap_tb.sv

//--- verification/accel_wrap_assert.sv
`timescale 1ns/1ns
`default_nettype none

module accel_wrap_assert (
  input logic                                 clk,
  input logic                                 rst,
  input logic                                 io_en,
  input logic                                 io_wen,
  input logic [accel_pkg::IO_ADDR_WIDTH-1:0]  io_addr,
  input logic                                 io_rd_valid,
  input logic [accel_pkg::DATA_WIDTH-1:0]     stream_data,
  input logic [accel_pkg::EMPTY_WIDTH-1:0]    stream_empty,
  input logic                                 stream_last,
  input logic                                 stream_valid,
  input logic                                 stream_ready,
  input logic                                 dma_stop
);

  logic rd_pending;
  int   fail_count = 0;

  // read issued and not yet answered
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_pending <= 1'b0;
    end else if (io_en && !io_wen) begin
      rd_pending <= 1'b1;
    end else if (io_rd_valid) begin
      rd_pending <= 1'b0;
    end
  end

  rd_valid_has_read: assert property (@(posedge clk) disable iff (rst)
    io_rd_valid |-> rd_pending)
    else begin
      $error("io_rd_valid without a read access");
      fail_count++;
    end

  // outside the burst window a read answers next cycle
  reg_read_answered: assert property (@(posedge clk) disable iff (rst)
    (io_en && !io_wen && io_addr[6:5] != 2'b10) |=> io_rd_valid)
    else begin
      $error("register read got no io_rd_valid");
      fail_count++;
    end

  stream_held: assert property (@(posedge clk) disable iff (rst)
    (stream_valid && !stream_ready && !dma_stop) |=>
      (stream_valid && $stable(stream_data) && $stable(stream_empty) && $stable(stream_last)))
    else begin
      $error("stream beat changed under back-pressure");
      fail_count++;
    end

  no_valid_in_reset: assert property (@(posedge clk)
    (rst && $past(rst)) |-> !stream_valid)
    else begin
      $error("stream_valid high during reset");
      fail_count++;
    end

endmodule

`default_nettype wire

//--- verification/accel_wrap_tb.sv
`timescale 1ns/1ns
`default_nettype none

module accel_wrap_tb;
  import accel_pkg::*;

  localparam logic [3:0] FT_TAG  = 4'ha;
  localparam logic [3:0] PKT_TAG = 4'h5;
  localparam int         TIMEOUT = 200;

  logic                      clk;
  logic                      rst;
  logic                      io_en;
  logic                      io_wen;
  logic [IO_STRB_WIDTH-1:0]  io_strb;
  logic [IO_ADDR_WIDTH-1:0]  io_addr;
  logic [IO_DATA_WIDTH-1:0]  io_wr_data;
  logic [IO_DATA_WIDTH-1:0]  io_rd_data;
  logic                      io_rd_valid;
  logic                      ft_en;
  logic [ACC_ADDR_WIDTH-1:0] ft_addr;
  logic                      pkt_en;
  logic [ACC_ADDR_WIDTH-1:0] pkt_addr;
  logic [DATA_WIDTH-1:0]     stream_data;
  logic [EMPTY_WIDTH-1:0]    stream_empty;
  logic                      stream_last;
  logic                      stream_valid;
  logic                      stream_ready;

  // memory model pipeline loaded on enable
  logic [HASH_TABLE_BLOCKS-1:0][DATA_WIDTH-1:0] ft_line_b1 = '0;
  logic [HASH_TABLE_BLOCKS-1:0][DATA_WIDTH-1:0] ft_line_b2 = '0;
  logic [HASH_TABLE_BLOCKS-1:0][DATA_WIDTH-1:0] ft_rd_data_b1 = '0;
  logic [HASH_TABLE_BLOCKS-1:0][DATA_WIDTH-1:0] ft_rd_data_b2 = '0;
  logic [DATA_WIDTH-1:0]                        pkt_line = '0;
  logic [DATA_WIDTH-1:0]                        pkt_rd_data = '0;

  // memory accesses seen on the enables
  int ft_reads  = 0;
  int pkt_reads = 0;
  int exp_pkt_reads = 0;

  logic [31:0]            lfsr;
  logic [DATA_WIDTH-1:0]  exp_data [$];
  logic [EMPTY_WIDTH-1:0] exp_empty [$];
  logic                   exp_last [$];

  accel_wrap accel_wrap_inst (.*);

  bind accel_wrap accel_wrap_assert accel_wrap_assert_inst (
    .clk         (clk),
    .rst         (rst),
    .io_en       (io_en),
    .io_wen      (io_wen),
    .io_addr     (io_addr),
    .io_rd_valid (io_rd_valid),
    .stream_data (stream_data),
    .stream_empty(stream_empty),
    .stream_last (stream_last),
    .stream_valid(stream_valid),
    .stream_ready(stream_ready),
    .dma_stop    (dma_stop)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // one memory word built from the whole line address
  function automatic logic [31:0] line_word(input logic [3:0] tag, input logic bank,
                                            input logic [1:0] blk, input logic [11:0] addr,
                                            input logic [1:0] w);
    return {tag, 1'b0, bank, blk, 2'b00, w, addr[7:0] ^ 8'h3c, addr};
  endfunction

  function automatic logic [DATA_WIDTH-1:0] mem_line(input logic [3:0] tag, input logic bank,
                                                     input logic [1:0] blk,
                                                     input logic [11:0] addr);
    logic [DATA_WIDTH-1:0] r;
    for (int w = 0; w < 4; w++) begin
      r[32*w +: 32] = line_word(tag, bank, blk, addr, 2'(w));
    end
    return r;
  endfunction

  always @(posedge clk) begin
    if (ft_en) begin
      for (int k = 0; k < HASH_TABLE_BLOCKS; k++) begin
        ft_line_b1[k] <= mem_line(FT_TAG, 1'b0, 2'(k), ft_addr);
        ft_line_b2[k] <= mem_line(FT_TAG, 1'b1, 2'(k), ft_addr);
      end
      ft_reads <= ft_reads + 1;
    end
    if (pkt_en) begin
      pkt_line  <= mem_line(PKT_TAG, 1'b0, 2'b00, pkt_addr);
      pkt_reads <= pkt_reads + 1;
    end
    ft_rd_data_b1 <= ft_line_b1;
    ft_rd_data_b2 <= ft_line_b2;
    pkt_rd_data   <= pkt_line;
  end

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] data,
                                              input logic [3:0] strb);
    logic [31:0] r;
    r = old;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        r[8*b +: 8] = data[8*b +: 8];
      end
    end
    return r;
  endfunction

  // bank 1 swaps the two halves of the result
  function automatic logic [31:0] burst_word(input logic bank, input logic [1:0] blk,
                                             input logic [11:0] addr, input int i);
    logic src_bank;
    src_bank = bank ^ (i >= 4);
    return line_word(FT_TAG, src_bank, blk, addr, 2'(i % 4));
  endfunction

  task automatic compare(input string name, input logic [DATA_WIDTH-1:0] got,
                         input logic [DATA_WIDTH-1:0] exp);
    if (got !== exp) begin
      $display("FAIL %s: got %h, expected %h", name, got, exp);
      $display("tests failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout: no %s within %0d cycles", what, TIMEOUT);
    $display("tests failed");
    $fatal(1, "simulation stopped on a timeout");
  endtask

  task automatic apply_reset();
    @(negedge clk);
    rst = 1'b1;
    repeat (16) @(negedge clk);
    rst = 1'b0;
  endtask

  task automatic bus_write(input logic [IO_ADDR_WIDTH-1:0] addr, input logic [31:0] data,
                           input logic [3:0] strb);
    @(negedge clk);
    io_en      = 1'b1;
    io_wen     = 1'b1;
    io_addr    = addr;
    io_wr_data = data;
    io_strb    = strb;
    @(negedge clk);
    io_en  = 1'b0;
    io_wen = 1'b0;
  endtask

  // address stays put until the data comes back
  task automatic read_and_check(input logic [IO_ADDR_WIDTH-1:0] addr, input logic [31:0] exp,
                                input string name);
    int n;
    @(negedge clk);
    io_en   = 1'b1;
    io_wen  = 1'b0;
    io_addr = addr;
    @(negedge clk);
    io_en = 1'b0;
    n = 0;
    while (!io_rd_valid) begin
      if (n == TIMEOUT) begin
        report_timeout("read data valid");
      end
      @(negedge clk);
      n++;
    end
    compare(name, io_rd_data, exp);
  endtask

  task automatic wait_stream_valid();
    int n;
    n = 0;
    while (!stream_valid) begin
      if (n == TIMEOUT) begin
        report_timeout("stream_valid");
      end
      @(negedge clk);
      n++;
    end
  endtask

  // queue a descriptor and append its expected beats
  task automatic push_desc(input logic [11:0] addr, input int len);
    int lines;
    logic [EMPTY_WIDTH-1:0] empty;
    bus_write(REG_DMA_LEN, 32'(len), 4'hf);
    bus_write(REG_DMA_ADDR, 32'(addr), 4'hf);
    bus_write(REG_CTRL, 32'h1, 4'h1);
    lines = (len + 15) / 16;
    if (lines == 0) begin
      lines = 1;
    end
    exp_pkt_reads += lines;
    empty = EMPTY_WIDTH'(lines * 16 - len);
    for (int i = 0; i < lines; i++) begin
      exp_data.push_back(mem_line(PKT_TAG, 1'b0, 2'b00, 12'(addr + i)));
      exp_last.push_back(i == lines - 1);
      exp_empty.push_back((i == lines - 1) ? empty : '0);
    end
  endtask

  task automatic drain_stream();
    int idle;
    logic [31:0] r;
    idle = 0;
    while (exp_data.size() != 0) begin
      @(negedge clk);
      r = rand_bits(2);
      stream_ready = (r != 0);
      if (stream_valid && stream_ready) begin
        compare("stream_data", stream_data, exp_data.pop_front());
        compare("stream_empty", stream_empty, exp_empty.pop_front());
        compare("stream_last", stream_last, exp_last.pop_front());
        idle = 0;
      end else begin
        if (idle == TIMEOUT) begin
          report_timeout("stream beat");
        end
        idle++;
      end
    end
    @(negedge clk);
    stream_ready = 1'b0;
  endtask

  task automatic check_registers();
    logic [31:0] exp_len;
    logic [31:0] exp_addr;
    logic [31:0] exp_mode;
    logic [31:0] data;
    logic [31:0] strb;
    logic [31:0] sel;
    bus_write(REG_DMA_LEN, 32'h0, 4'hf);
    bus_write(REG_DMA_ADDR, 32'h0, 4'hf);
    bus_write(REG_FLOW_MODE, 32'h0, 4'hf);
    exp_len  = '0;
    exp_addr = '0;
    exp_mode = '0;
    repeat (24) begin
      data = rand_bits(32);
      strb = rand_bits(4);
      sel  = rand_bits(2);
      case (sel)
        0: begin
          bus_write(REG_DMA_LEN, data, strb[3:0]);
          exp_len = merge_bytes(exp_len, data, strb[3:0]) & 32'h0000_3fff;
        end
        1: begin
          bus_write(REG_DMA_ADDR, data, strb[3:0]);
          exp_addr = merge_bytes(exp_addr, data, strb[3:0]) & 32'h0000_0fff;
        end
        default: begin
          bus_write(REG_FLOW_MODE, data, strb[3:0]);
          if (strb[0]) begin
            exp_mode = {31'd0, data[0]};
          end
        end
      endcase
      read_and_check(REG_DMA_LEN, exp_len, "io_rd_data dma len");
      read_and_check(REG_DMA_ADDR, exp_addr, "io_rd_data dma addr");
      read_and_check(REG_FLOW_MODE, exp_mode, "io_rd_data flow mode");
    end
    read_and_check(7'h00, 32'h0, "io_rd_data ctrl");
    read_and_check(7'h0c, 32'h0, "io_rd_data unmapped");
    read_and_check(7'h7c, 32'h0, "io_rd_data unmapped");
  endtask

  task automatic check_bursts();
    logic [31:0] mode;
    logic [31:0] req;
    logic [31:0] dly;
    logic [11:0] addr;
    logic [1:0]  blk;
    logic        bank;
    int          base;
    repeat (16) begin
      mode = rand_bits(1);
      req  = rand_bits(32);
      dly  = rand_bits(3);
      base = ft_reads;
      bus_write(REG_FLOW_MODE, mode, 4'h1);
      bus_write(REG_FLOW_REQ, req, 4'hf);
      if (mode[0]) begin
        addr = req[11:0];
        blk  = req[13:12];
        bank = 1'b0;
      end else begin
        addr = req[12:1];
        blk  = req[14:13];
        bank = req[0];
      end
      // short delays make the first read stall
      repeat (dly) @(negedge clk);
      for (int i = 0; i < 8; i++) begin
        read_and_check(7'(REG_FLOW_BURST_BASE + 4 * i), burst_word(bank, blk, addr, i),
                       "io_rd_data burst");
      end
      // one memory access per request
      compare("ft_en pulses", ft_reads - base, 1);
    end
  endtask

  task automatic check_status();
    apply_reset();
    push_desc(12'h123, 40);
    wait_stream_valid();
    read_and_check(REG_STATUS, 32'h0000_0001, "io_rd_data status busy");
    drain_stream();
    read_and_check(REG_STATUS, 32'h0000_0100, "io_rd_data status done");

    // stop in the middle of a stream
    apply_reset();
    push_desc(12'h200, 64);
    wait_stream_valid();
    bus_write(REG_CTRL, 32'h4, 4'h1);
    exp_data.delete();
    exp_empty.delete();
    exp_last.delete();
    repeat (2) @(negedge clk);
    compare("stream_valid", stream_valid, 1'b0);
    read_and_check(REG_STATUS, 32'h0000_0100, "io_rd_data status stop");

    // busy again while done is still set
    push_desc(12'h3f0, 20);
    wait_stream_valid();
    read_and_check(REG_STATUS, 32'h0001_0101, "io_rd_data status error");
    drain_stream();
    read_and_check(REG_STATUS, 32'h0001_0100, "io_rd_data status final");
  endtask

  initial begin
    logic [31:0] a;
    logic [31:0] l;
    logic [31:0] n;
    rst          = 1'b1;
    io_en        = 1'b0;
    io_wen       = 1'b0;
    io_strb      = '0;
    io_addr      = '0;
    io_wr_data   = '0;
    stream_ready = 1'b0;
    lfsr         = 32'h0930_bafa;
    apply_reset();

    check_registers();
    check_bursts();

    // one descriptor at a time
    repeat (8) begin
      a = rand_bits(12);
      l = rand_bits(7);
      push_desc(a[11:0], int'(l));
      drain_stream();
    end

    // back to back descriptors come out in order
    repeat (3) begin
      n = rand_bits(2) + 2;
      repeat (n) begin
        a = rand_bits(12);
        l = rand_bits(7);
        push_desc(a[11:0], int'(l));
      end
      drain_stream();
    end

    // every line fetched exactly once
    compare("pkt_en pulses", pkt_reads, exp_pkt_reads);

    check_status();
    if (accel_wrap_inst.accel_wrap_assert_inst.fail_count != 0) begin
      $display("bound assertions failed %0d times",
               accel_wrap_inst.accel_wrap_assert_inst.fail_count);
      $display("tests failed");
      $fatal(1, "assertion failures");
    end else begin
      $display("all tests passed");
      $finish;
    end
  end

endmodule

`default_nettype wire
